//--- hdl/alu_pkg.sv
package alu_pkg;

   localparam int ALU_DATA_WIDTH = 16;   // operand width used by the top level

   // sequencer states, the encodings match the 3-bit state field
   typedef enum logic [2:0] {
      SM_IDLE    = 3'd0,
      SM_SIGN_B  = 3'd1,                  // negate the second operand
      SM_SIGN_Q  = 3'd2,                  // negate the result
      SM_MUL     = 3'd3,
      SM_DIV_R   = 3'd4,                  // shift the next dividend bit into r
      SM_DIV_CMP = 3'd5,                  // trial subtract
      SM_DIV_CNT = 3'd6                   // bit counter
   } alu_state_t;

endpackage

//--- hdl/adder.sv
`timescale 1ns/1ps
module adder #(
   parameter int DATA_WIDTH = alu_pkg::ALU_DATA_WIDTH
) (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf
);

   logic same_sign;

   assign same_sign = (i_a[DATA_WIDTH-1] == i_b[DATA_WIDTH-1]);

   assign o_q   = i_a + i_b;                                       // wraps at N bits
   assign o_ovf = same_sign & (o_q[DATA_WIDTH-1] != i_a[DATA_WIDTH-1]);   // sign flipped

endmodule

//--- hdl/sequential_alu.sv
`timescale 1ns/1ps
module sequential_alu #(
   parameter int DATA_WIDTH = alu_pkg::ALU_DATA_WIDTH
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_accept
);

   import alu_pkg::*;

   localparam int                       CNT_WIDTH = $clog2(DATA_WIDTH);
   localparam logic [CNT_WIDTH-1:0]     CNT_LAST  = CNT_WIDTH'(DATA_WIDTH - 1);
   localparam logic signed [DATA_WIDTH-1:0] ONE   = DATA_WIDTH'(1);

   alu_state_t                   state;
   logic [DATA_WIDTH-1:0]        a;            // first magnitude, shifted during the loop
   logic [DATA_WIDTH-1:0]        b;            // second magnitude
   logic [DATA_WIDTH-1:0]        r;            // partial remainder
   logic [CNT_WIDTH-1:0]         cnt;          // divide bit counter
   logic                         neg_q;        // result sign, captured at setup
   logic                         op_mul;       // multiply or divide after SM_SIGN_B

   logic                         a_neg;
   logic                         b_neg;
   logic                         b_min;
   logic                         b_zero;
   logic                         a_rest_zero;
   logic                         diff_pos;
   logic signed [DATA_WIDTH-1:0] adder_a;
   logic signed [DATA_WIDTH-1:0] adder_b;
   logic signed [DATA_WIDTH-1:0] adder_q;
   logic                         adder_ovf;

   assign a_neg       = i_a[DATA_WIDTH-1];
   assign b_neg       = i_b[DATA_WIDTH-1];
   assign b_min       = b_neg & ~|i_b[DATA_WIDTH-2:0];
   assign b_zero      = ~|i_b;
   assign a_rest_zero = ~|a[DATA_WIDTH-1:1];   // last multiplier bit reached
   // r - b is formed as ~(~r + b), so a negative raw sum means r >= b
   assign diff_pos    = adder_q[DATA_WIDTH-1];

   // adder input steering, negation is ~x + 1 through the same adder
   always_comb begin
      adder_a = o_q;                           // SM_MUL accumulates o_q + b
      adder_b = b;
      case (state)
         SM_IDLE: begin
            if (i_add) begin
               adder_a = i_a;
               adder_b = i_b;
            end else if (i_sub) begin
               adder_a = ~i_a;                 // a - b = ~(~a + b)
               adder_b = i_b;
            end else if (a_neg) begin
               adder_a = ~i_a;                 // |a|
               adder_b = ONE;
            end else begin
               adder_a = ONE;                  // |b| when only b is negative
               adder_b = ~i_b;
            end
         end
         SM_SIGN_B: begin
            adder_a = ONE;
            adder_b = ~b;
         end
         SM_SIGN_Q: begin
            adder_a = ~o_q;
            adder_b = ONE;
         end
         SM_DIV_CMP: begin
            adder_a = ~r;
            adder_b = b;
         end
         SM_DIV_CNT: begin
            adder_a = DATA_WIDTH'(cnt);
            adder_b = ONE;
         end
         default: ;
      endcase
   end

   adder #(
      .DATA_WIDTH (DATA_WIDTH)
   ) adder_i (
      .i_a   (adder_a),
      .i_b   (adder_b),
      .o_q   (adder_q),
      .o_ovf (adder_ovf)
   );

   // sequencer and result registers
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= SM_IDLE;
         cnt      <= '0;
         neg_q    <= 1'b0;
         op_mul   <= 1'b0;
         o_q      <= '0;
         o_ovf    <= 1'b0;
         o_zero   <= 1'b0;
         o_accept <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         o_ovf    <= 1'b0;
         o_zero   <= 1'b0;
         case (state)
            SM_IDLE: begin
               if (i_add) begin
                  o_q      <= adder_q;
                  o_ovf    <= adder_ovf;
                  o_accept <= 1'b1;
               end else if (i_sub) begin
                  o_q      <= ~adder_q;
                  o_ovf    <= adder_ovf | b_min;   // -b does not fit for the most negative b
                  o_accept <= 1'b1;
               end else if (i_mul | i_div) begin
                  o_q    <= '0;
                  neg_q  <= a_neg ^ b_neg;
                  op_mul <= i_mul;
                  if (!i_mul && b_zero) begin      // divide by zero
                     o_ovf    <= 1'b1;
                     o_zero   <= 1'b1;
                     o_accept <= 1'b1;
                  end else if ((a_neg | b_neg) && adder_ovf) begin   // most negative operand
                     o_ovf    <= 1'b1;
                     o_accept <= 1'b1;
                  end else if (a_neg && b_neg) begin
                     state <= SM_SIGN_B;
                  end else begin
                     state <= i_mul ? SM_MUL : SM_DIV_R;
                  end
               end
            end
            SM_SIGN_B: begin
               if (adder_ovf) begin
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
                  state    <= SM_IDLE;
               end else begin
                  state <= op_mul ? SM_MUL : SM_DIV_R;
               end
            end
            SM_SIGN_Q: begin
               o_q      <= adder_q;
               o_accept <= 1'b1;
               state    <= SM_IDLE;
            end
            SM_MUL: begin
               // b reaching the sign bit while a still has bits left means product >= 2^(N-1)
               if (b[DATA_WIDTH-1] || (a[0] && adder_ovf)) begin
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
                  state    <= SM_IDLE;
               end else begin
                  if (a[0])
                     o_q <= adder_q;
                  if (a_rest_zero) begin
                     if (neg_q) begin
                        state <= SM_SIGN_Q;
                     end else begin
                        o_accept <= 1'b1;
                        state    <= SM_IDLE;
                     end
                  end
               end
            end
            SM_DIV_R: begin
               state <= SM_DIV_CMP;
            end
            SM_DIV_CMP: begin
               o_q   <= {o_q[DATA_WIDTH-2:0], diff_pos};   // quotient bit in from the right
               state <= SM_DIV_CNT;
            end
            SM_DIV_CNT: begin
               if (cnt == CNT_LAST) begin
                  cnt <= '0;
                  if (neg_q) begin
                     state <= SM_SIGN_Q;
                  end else begin
                     o_accept <= 1'b1;
                     state    <= SM_IDLE;
                  end
               end else begin
                  cnt   <= adder_q[CNT_WIDTH-1:0];
                  state <= SM_DIV_R;
               end
            end
            default: state <= SM_IDLE;
         endcase
      end
   end

   // operand and remainder registers
   always_ff @(posedge i_clk) begin
      case (state)
         SM_IDLE: begin
            a <= a_neg ? adder_q : i_a;             // meaningful only after a mul or div strobe
            b <= (b_neg && !a_neg) ? adder_q : i_b;
            r <= '0;
         end
         SM_SIGN_B: begin
            b <= adder_q;
         end
         SM_MUL: begin
            a <= a >> 1;
            b <= b << 1;
         end
         SM_DIV_R: begin
            r <= {r[DATA_WIDTH-2:0], a[DATA_WIDTH-1]};
            a <= a << 1;
         end
         SM_DIV_CMP: begin
            if (diff_pos)
               r <= ~adder_q;                       // keep r - b
         end
         default: ;
      endcase
   end

endmodule

//--- hdl/alu_top.sv
`timescale 1ns/1ps
module alu_top #(
   parameter int DATA_WIDTH = alu_pkg::ALU_DATA_WIDTH
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_accept
);

   // single arithmetic unit, width set here for the whole tree
   sequential_alu #(
      .DATA_WIDTH (DATA_WIDTH)
   ) sequential_alu_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_a      (i_a),
      .i_b      (i_b),
      .i_add    (i_add),
      .i_sub    (i_sub),
      .i_mul    (i_mul),
      .i_div    (i_div),
      .o_q      (o_q),
      .o_ovf    (o_ovf),
      .o_zero   (o_zero),
      .o_accept (o_accept)
   );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 2
) (
   output logic o_clk,
   output logic o_nrst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   initial begin
      o_nrst <= 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_nrst <= 1'b1;                            // release on a rising edge
   end

endmodule

//--- verif/alu_properties.sv
`timescale 1ns/1ps
module alu_properties (
   input logic                i_clk,
   input logic                i_nrst,
   input logic                i_add,
   input logic                i_sub,
   input logic                i_mul,
   input logic                i_div,
   input logic                i_accept,
   input logic                i_ovf,
   input logic                i_zero,
   input alu_pkg::alu_state_t i_state
);

   import alu_pkg::*;

   accept_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_accept |=> !i_accept)
      else $error("o_accept stayed high for two cycles");

   flags_with_accept: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_ovf || i_zero) |-> i_accept)
      else $error("o_ovf or o_zero raised without o_accept");

   zero_with_ovf: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_zero |-> i_ovf)
      else $error("o_zero raised without o_ovf");

   // an idle sequencer with no strobe produces no result
   no_accept_when_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
      ((i_state == SM_IDLE) && !(i_add || i_sub || i_mul || i_div)) |=> !i_accept)
      else $error("o_accept raised without a command");

endmodule

bind sequential_alu alu_properties alu_properties_i (
   .i_clk    (i_clk),
   .i_nrst   (i_nrst),
   .i_add    (i_add),
   .i_sub    (i_sub),
   .i_mul    (i_mul),
   .i_div    (i_div),
   .i_accept (o_accept),
   .i_ovf    (o_ovf),
   .i_zero   (o_zero),
   .i_state  (state)
);

//--- verif/alu_tb.sv
`timescale 1ns/1ps
module alu_tb;

   import alu_pkg::*;

   localparam int W            = ALU_DATA_WIDTH;
   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 2;
   localparam int N_RANDOM     = 50;
   localparam int N_SMALL      = 25;
   localparam int N_DISTURB    = 10;
   localparam int N_CMDS       = 4 * 64 + 4 * N_RANDOM + 4 * N_SMALL + 2 * N_DISTURB;
   localparam int WATCHDOG_NS  = (N_CMDS * (3 * W + 6) + RESET_CYCLES) * CLK_PERIOD;
   localparam int OP_ADD       = 0;
   localparam int OP_SUB       = 1;
   localparam int OP_MUL       = 2;
   localparam int OP_DIV       = 3;

   typedef logic signed [W-1:0] word_t;

   localparam word_t  MIN_VAL = {1'b1, {(W-1){1'b0}}};
   localparam longint LIM     = longint'(1) << (W - 1);   // 2^(N-1)

   logic   i_clk;
   logic   i_nrst;
   word_t  i_a;
   word_t  i_b;
   logic   i_add;
   logic   i_sub;
   logic   i_mul;
   logic   i_div;
   word_t  o_q;
   logic   o_ovf;
   logic   o_zero;
   logic   o_accept;

   integer seed;
   int     n_accept;                  // o_accept pulses seen
   int     n_done;                    // commands completed
   logic   prev_accept;
   word_t  corners [8];

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) clock_gen_i (
      .o_clk  (i_clk),
      .o_nrst (i_nrst)
   );

   alu_top alu_top_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_a      (i_a),
      .i_b      (i_b),
      .i_add    (i_add),
      .i_sub    (i_sub),
      .i_mul    (i_mul),
      .i_div    (i_div),
      .o_q      (o_q),
      .o_ovf    (o_ovf),
      .o_zero   (o_zero),
      .o_accept (o_accept)
   );

   task automatic report_failure(input string what);
      $display("Failure at %0t ns: %s", $time, what);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_result(input string name, input word_t exp_v, input word_t act_v);
      if (act_v !== exp_v) begin
         $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   function automatic word_t rand_word();
      logic [31:0] rnd;
      rnd = $random(seed);
      return rnd[W-1:0];
   endfunction

   function automatic word_t small_word();
      logic [31:0] rnd;
      rnd = $random(seed);
      return word_t'($signed(rnd[W/2-1:0]));   // half width, the product always fits
   endfunction

   // reference model in wide integers
   function automatic void expected_result(input int op, input word_t a, input word_t b,
                                           output word_t q, output logic ovf,
                                           output logic zero);
      longint la;
      longint lb;
      longint res;
      la   = longint'(a);
      lb   = longint'(b);
      res  = 0;
      ovf  = 1'b0;
      zero = 1'b0;
      case (op)
         OP_ADD: begin
            res = la + lb;
            ovf = (res >= LIM) || (res < -LIM);
         end
         OP_SUB: begin
            res = la - lb;
            ovf = (res >= LIM) || (res < -LIM) || (b == MIN_VAL);
         end
         OP_MUL: begin
            res = la * lb;
            ovf = (a == MIN_VAL) || (b == MIN_VAL) ||
                  (((la < 0) ? -la : la) * ((lb < 0) ? -lb : lb) >= LIM);
         end
         default: begin
            if (b == '0) begin
               zero = 1'b1;
               ovf  = 1'b1;
            end else begin
               ovf = (a == MIN_VAL) || (b == MIN_VAL);
               res = la / lb;                  // truncates toward zero
            end
         end
      endcase
      q = res[W-1:0];
   endfunction

   task automatic drive_strobes(input logic [3:0] s);
      i_add <= s[0];
      i_sub <= s[1];
      i_mul <= s[2];
      i_div <= s[3];
   endtask

   // one command, optionally with noise on the inputs while it runs
   task automatic run_command(input int op, input word_t a, input word_t b,
                              input int n_disturb);
      word_t       exp_q;
      logic        exp_ovf;
      logic        exp_zero;
      logic [31:0] rnd;
      expected_result(op, a, b, exp_q, exp_ovf, exp_zero);
      @(posedge i_clk);
      if (n_accept != n_done)
         report_failure("o_accept count does not match the commands issued");
      i_a <= a;
      i_b <= b;
      drive_strobes(4'b0001 << op);
      @(posedge i_clk);
      drive_strobes(4'b0000);
      repeat (n_disturb) begin
         i_a <= rand_word();
         i_b <= rand_word();
         rnd = $random(seed);
         drive_strobes(rnd[31:28]);            // must be ignored while busy
         @(posedge i_clk);
      end
      drive_strobes(4'b0000);
      do
         @(negedge i_clk);
      while (!o_accept);
      if (op == OP_ADD || op == OP_SUB || !exp_ovf)
         check_result("o_q", exp_q, o_q);
      check_flag("o_ovf", exp_ovf, o_ovf);
      check_flag("o_zero", exp_zero, o_zero);
      n_done = n_done + 1;
   endtask

   // output protocol, seen mid-cycle
   always @(negedge i_clk) begin
      if (i_nrst) begin
         if (o_accept)
            n_accept = n_accept + 1;
         if (o_accept && prev_accept)
            report_failure("o_accept stayed high for two cycles");
         if ((o_ovf || o_zero) && !o_accept)
            report_failure("o_ovf or o_zero raised without o_accept");
         if (o_zero && !o_ovf)
            report_failure("o_zero raised without o_ovf");
         prev_accept = o_accept;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      report_failure("timeout, the commands did not all complete in time");
   end

   initial begin
      int    op;
      int    i;
      int    j;
      word_t b;
      seed        = 32'hdef5d020;
      n_accept    = 0;
      n_done      = 0;
      prev_accept = 1'b0;
      i_a   <= '0;
      i_b   <= '0;
      i_add <= 1'b0;
      i_sub <= 1'b0;
      i_mul <= 1'b0;
      i_div <= 1'b0;
      corners[0] = '0;
      corners[1] = word_t'(1);
      corners[2] = '1;
      corners[3] = word_t'(2);
      corners[4] = word_t'(-2);
      corners[5] = MIN_VAL;
      corners[6] = ~MIN_VAL;
      corners[7] = MIN_VAL + word_t'(1);

      @(posedge i_nrst);
      @(negedge i_clk);
      check_flag("o_accept", 1'b0, o_accept);
      check_flag("o_ovf", 1'b0, o_ovf);
      check_flag("o_zero", 1'b0, o_zero);
      check_result("o_q", '0, o_q);

      for (op = 0; op < 4; op++)
         for (i = 0; i < 8; i++)
            for (j = 0; j < 8; j++)
               run_command(op, corners[i], corners[j], 0);
      repeat (N_RANDOM)
         for (op = 0; op < 4; op++)
            run_command(op, rand_word(), rand_word(), 0);
      repeat (N_SMALL)
         for (op = 0; op < 4; op++)
            run_command(op, small_word(), small_word(), 0);
      repeat (N_DISTURB) begin
         b = small_word();
         if (b == '0)
            b = word_t'(1);
         run_command(OP_MUL, small_word(), b, 1);
         run_command(OP_DIV, small_word(), b, 2 * W);
      end

      repeat (4) @(posedge i_clk);
      if (n_accept != n_done)
         report_failure("extra o_accept after the last command");
      $display("All checks passed");
      $finish;
   end

endmodule

//--- all.f
hdl/alu_pkg.sv
hdl/adder.sv
hdl/sequential_alu.sv
hdl/alu_top.sv
verif/tb_clock_gen.sv
verif/alu_properties.sv
verif/alu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= alu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
